// ==== source/tlp_rcv_pkg.sv ====
// shared codes, widths and beat/field structs of the TLP receive path
// header bit positions assume a 128-bit beat carrying the whole 4-DW header

package tlp_rcv_pkg;

    //////////////////////////////////////////////////////////////////////
    // fmt/type byte codes
    //////////////////////////////////////////////////////////////////////
    localparam logic [7:0] TLP_MRD32   = 8'h00;
    localparam logic [7:0] TLP_MRD64   = 8'h20;
    localparam logic [7:0] TLP_MRDLK32 = 8'h01;
    localparam logic [7:0] TLP_MRDLK64 = 8'h21;
    localparam logic [7:0] TLP_MWR32   = 8'h40;
    localparam logic [7:0] TLP_MWR64   = 8'h60;
    localparam logic [7:0] TLP_CPLD    = 8'h4A;
    localparam logic [7:0] TLP_CPLDLK  = 8'h4B;

    // field widths
    localparam int BEAT_W   = 128;
    localparam int KEEP_W   = 4;
    localparam int USER_W   = 8;
    localparam int LEN_W    = 10;
    localparam int ADDR_W   = 64;
    localparam int TAG_W    = 8;
    localparam int REQ_ID_W = 16;

    // user sideband layout
    localparam int USER_LAST_CPL_BIT = 3;
    localparam int USER_BAR_LSB      = 4;

    //////////////////////////////////////////////////////////////////////
    // structs
    //////////////////////////////////////////////////////////////////////
    typedef struct packed {
        logic                valid;
        logic [BEAT_W-1:0]   data;
        logic [KEEP_W-1:0]   keep;
        logic                last;
        logic [USER_W-1:0]   user;
    } axis_beat_t;

    typedef enum logic [1:0] {
        KIND_NONE = 2'd0,
        KIND_MRD  = 2'd1,
        KIND_MWR  = 2'd2,
        KIND_CPLD = 2'd3
    } tlp_kind_e;

    typedef struct packed {
        logic [2:0]          tc;
        logic [2:0]          attr;
        logic [LEN_W-1:0]    len;
        logic [REQ_ID_W-1:0] req_id;
        logic [TAG_W-1:0]    tag;
        logic [ADDR_W-1:0]   addr;
    } mrd_req_t;

    typedef struct packed {
        logic [LEN_W-1:0]    len;
        logic [7:0]          dwbe;
        logic [ADDR_W-1:0]   addr;
    } mwr_hdr_t;

    typedef struct packed {
        logic [LEN_W-1:0]    len;
        logic [6:0]          low_addr;
        logic [11:0]         byte_cnt;
        logic [TAG_W-1:0]    tag;
        logic                multi_cpl;
    } cpld_hdr_t;

    typedef struct packed {
        logic [BEAT_W-1:0]   data;
        logic [KEEP_W-1:0]   dw_vld;
    } data_beat_t;

    // little to big endian, byte order reversed inside each DW
    function automatic logic [BEAT_W-1:0] endian_swap(input logic [BEAT_W-1:0] din);
        logic [BEAT_W-1:0] dout;
        for (int dw = 0; dw < KEEP_W; dw++)
        begin
            for (int b = 0; b < 4; b++)
            begin
                dout[32*dw + 8*b +: 8] = din[32*dw + 8*(3-b) +: 8];
            end
        end
        return dout;
    endfunction

endpackage

// ==== source/axis_rx_pipe.sv ====
// two register stages on the incoming stream beat
// s1 gives look-ahead valid/last, s2 carries the header and payload
`timescale 1ns/1ps

module axis_rx_pipe (
    input  logic                    clk,
    input  logic                    rst_n,
    input  tlp_rcv_pkg::axis_beat_t i_beat,
    output tlp_rcv_pkg::axis_beat_t o_s1,
    output tlp_rcv_pkg::axis_beat_t o_s2
);

    import tlp_rcv_pkg::*;

    // first stage
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            o_s1 <= '0;
        end
        else
        begin
            o_s1 <= i_beat;
        end
    end

    // second stage, lines up with the fsm state
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            o_s2 <= '0;
        end
        else
        begin
            o_s2 <= o_s1;
        end
    end

endmodule

// ==== source/tlp_hdr_decode.sv ====
// receive fsm and header field capture
// kind and header strobe are combinational on the s2 header beat
// held fields are only meaningful after their header strobe
`timescale 1ns/1ps

module tlp_hdr_decode (
    input  logic                    clk,
    input  logic                    rst_n,
    input  tlp_rcv_pkg::axis_beat_t i_s1,
    input  tlp_rcv_pkg::axis_beat_t i_s2,
    output logic                    o_state_hdr,
    output tlp_rcv_pkg::tlp_kind_e  o_kind,
    output logic                    o_hdr_strobe,
    output tlp_rcv_pkg::mrd_req_t   o_mrd,
    output tlp_rcv_pkg::mwr_hdr_t   o_mwr,
    output tlp_rcv_pkg::cpld_hdr_t  o_cpld
);

    import tlp_rcv_pkg::*;

    typedef enum logic [1:0] {
        IDLE     = 2'd0,
        HEAD_RCV = 2'd1,
        DATA_RCV = 2'd2
    } rcv_state_e;

    rcv_state_e          state;
    rcv_state_e          next_state;
    logic                hdr_vld;
    logic                with_data;
    logic                eop;
    logic [7:0]          fmt_type;
    logic [ADDR_W-1:0]   hdr_addr;

    ////////////////////////////////////////////////////////////////////////
    // fsm
    ////////////////////////////////////////////////////////////////////////
    assign with_data = i_s2.valid && i_s2.data[30];
    assign eop       = i_s2.valid && i_s2.last;

    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            state <= IDLE;
        end
        else
        begin
            state <= next_state;
        end
    end

    always_comb
    begin
        next_state = state;
        case (state)
            IDLE:
            begin
                if (i_s1.valid)
                    next_state = HEAD_RCV;
            end
            HEAD_RCV:
            begin
                // header only tlp with nothing behind it drops to idle
                if (with_data)
                    next_state = DATA_RCV;
                else if (!i_s1.valid)
                    next_state = IDLE;
            end
            DATA_RCV:
            begin
                if (eop && i_s1.valid)
                    next_state = HEAD_RCV;
                else if (eop)
                    next_state = IDLE;
            end
            default:
            begin
                next_state = IDLE;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////////////////
    // kind decode
    ////////////////////////////////////////////////////////////////////////
    assign o_state_hdr = (state == HEAD_RCV);
    assign hdr_vld     = o_state_hdr && i_s2.valid;
    assign fmt_type    = i_s2.data[31:24];

    always_comb
    begin
        o_kind = KIND_NONE;
        if (hdr_vld)
        begin
            case (fmt_type)
                TLP_MRD32, TLP_MRD64, TLP_MRDLK32, TLP_MRDLK64:
                    o_kind = KIND_MRD;
                TLP_MWR32, TLP_MWR64:
                    o_kind = KIND_MWR;
                TLP_CPLD, TLP_CPLDLK:
                    o_kind = KIND_CPLD;
                default:
                    o_kind = KIND_NONE;
            endcase
        end
    end

    // unsupported headers give no strobe
    assign o_hdr_strobe = (o_kind != KIND_NONE);

    // fmt bit 29 selects the 4-DW form with a 64-bit address
    assign hdr_addr = i_s2.data[29] ? {i_s2.data[95:64], i_s2.data[127:98], 2'b00}
                                    : {32'h0, i_s2.data[95:66], 2'b00};

    ////////////////////////////////////////////////////////////////////////
    // field capture
    ////////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk)
    begin
        if (o_kind == KIND_MRD)
        begin
            o_mrd.tc     <= i_s2.data[22:20];
            o_mrd.attr   <= {i_s2.data[18], i_s2.data[13:12]};
            o_mrd.len    <= i_s2.data[LEN_W-1:0];
            o_mrd.req_id <= i_s2.data[63:48];
            o_mrd.tag    <= i_s2.data[47:40];
            o_mrd.addr   <= hdr_addr;
        end
    end

    always_ff @(posedge clk)
    begin
        if (o_kind == KIND_MWR)
        begin
            o_mwr.len  <= i_s2.data[LEN_W-1:0];
            o_mwr.dwbe <= i_s2.data[39:32];
            o_mwr.addr <= hdr_addr;
        end
    end

    // completer tag and low address sit in the third DW
    always_ff @(posedge clk)
    begin
        if (o_kind == KIND_CPLD)
        begin
            o_cpld.len       <= i_s2.data[LEN_W-1:0];
            o_cpld.byte_cnt  <= i_s2.data[43:32];
            o_cpld.low_addr  <= i_s2.data[70:64];
            o_cpld.tag       <= i_s2.data[79:72];
            o_cpld.multi_cpl <= ~i_s2.user[USER_LAST_CPL_BIT];
        end
    end

endmodule

// ==== source/tlp_payload_route.sv ====
// routes payload beats of MWr and CplD to their write ports
// one start strobe per s2 payload beat, data byte-swapped per DW
// payload of any other kind is dropped
`timescale 1ns/1ps

module tlp_payload_route (
    input  logic                    clk,
    input  logic                    rst_n,
    input  tlp_rcv_pkg::axis_beat_t i_s2,
    input  logic                    i_state_hdr,
    input  tlp_rcv_pkg::tlp_kind_e  i_kind,
    output tlp_rcv_pkg::data_beat_t o_mwr_beat,
    output logic                    o_mwr_wr_start,
    output tlp_rcv_pkg::data_beat_t o_cpld_beat,
    output logic                    o_cpld_wr_start,
    output logic [1:0]              o_bar_hit
);

    import tlp_rcv_pkg::*;

    tlp_kind_e           pay_kind;
    logic                data_beat;
    logic                mwr_beat;
    logic                cpld_beat;
    logic [BEAT_W-1:0]   swap_data;

    assign data_beat = i_s2.valid && !i_state_hdr;
    assign mwr_beat  = data_beat && (pay_kind == KIND_MWR);
    assign cpld_beat = data_beat && (pay_kind == KIND_CPLD);
    assign swap_data = endian_swap(i_s2.data);

    // payload kind held from header to last beat
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            pay_kind <= KIND_NONE;
        else if (i_s2.valid && i_s2.last)
            pay_kind <= KIND_NONE;
        else if (i_state_hdr && i_s2.valid)
            pay_kind <= i_kind;
    end

    //////////////////////////////////////////////////////////////////////
    // start strobes and bar hit
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
        begin
            o_mwr_wr_start  <= 1'b0;
            o_cpld_wr_start <= 1'b0;
            o_bar_hit       <= 2'b00;
        end
        else
        begin
            o_mwr_wr_start  <= mwr_beat;
            o_cpld_wr_start <= cpld_beat;
            if (mwr_beat || cpld_beat)
                o_bar_hit <= i_s2.user[USER_BAR_LSB +: 2];
        end
    end

    // payload registers
    always_ff @(posedge clk)
    begin
        if (mwr_beat)
        begin
            o_mwr_beat.data   <= swap_data;
            o_mwr_beat.dw_vld <= i_s2.keep;
        end
        if (cpld_beat)
        begin
            o_cpld_beat.data   <= swap_data;
            o_cpld_beat.dw_vld <= i_s2.keep;
        end
    end

endmodule

// ==== source/tlp_rcv_flow_ctrl.sv ====
// completion request handshake, tag release and receive halt vector
// a new MRd while a request is pending overwrites the held fields
`timescale 1ns/1ps

module tlp_rcv_flow_ctrl (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   i_hdr_strobe,
    input  tlp_rcv_pkg::tlp_kind_e i_kind,
    input  logic                   i_last_cpl,
    input  logic                   i_cpld_req_rdy,
    input  logic                   i_cpld_tx_rdy,
    input  logic                   i_tag_full,
    output logic                   o_cpld_req_vld,
    output logic                   o_cpld_rcv,
    output logic [2:0]             o_pkt_halt
);

    import tlp_rcv_pkg::*;

    // request held until the tx side takes it
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            o_cpld_req_vld <= 1'b0;
        else if (i_hdr_strobe && (i_kind == KIND_MRD))
            o_cpld_req_vld <= 1'b1;
        else if (i_cpld_req_rdy)
            o_cpld_req_vld <= 1'b0;
    end

    // tag release only on the last completion of a request
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            o_cpld_rcv <= 1'b0;
        else
            o_cpld_rcv <= i_hdr_strobe && (i_kind == KIND_CPLD) && i_last_cpl;
    end

    // bit0 posted, bit1 non-posted, bit2 completions
    always_ff @(posedge clk or negedge rst_n)
    begin
        if (!rst_n)
            o_pkt_halt <= 3'b000;
        else
            o_pkt_halt <= {i_tag_full, ~i_cpld_tx_rdy, 1'b0};
    end

endmodule

// ==== source/tlp_rcv_top.sv ====
// receive side of the DMA endpoint, fed by a 128-bit stream master port
// the input is always ready; only the completion request sees back-pressure
`timescale 1ns/1ps

module tlp_rcv_top (
    input  logic                    clk,
    input  logic                    rst_n,
    input  tlp_rcv_pkg::axis_beat_t i_axis,
    output logic                    o_axis_trdy,
    output tlp_rcv_pkg::mrd_req_t   o_mrd,
    output logic                    o_cpld_req_vld,
    input  logic                    i_cpld_req_rdy,
    input  logic                    i_cpld_tx_rdy,
    output tlp_rcv_pkg::mwr_hdr_t   o_mwr,
    output tlp_rcv_pkg::data_beat_t o_mwr_beat,
    output logic                    o_mwr_wr_start,
    output tlp_rcv_pkg::cpld_hdr_t  o_cpld,
    output tlp_rcv_pkg::data_beat_t o_cpld_beat,
    output logic                    o_cpld_wr_start,
    output logic                    o_multicpld_flag,
    output logic [1:0]              o_bar_hit,
    output logic                    o_cpld_rcv,
    input  logic                    i_tag_full,
    output logic [2:0]              o_pkt_halt
);

    import tlp_rcv_pkg::*;

    axis_beat_t  s1;
    axis_beat_t  s2;
    logic        state_hdr;
    tlp_kind_e   kind;
    logic        hdr_strobe;

    assign o_axis_trdy      = 1'b1;
    assign o_multicpld_flag = o_cpld.multi_cpl;

    axis_rx_pipe u_pipe (
        .clk     (clk),
        .rst_n   (rst_n),
        .i_beat  (i_axis),
        .o_s1    (s1),
        .o_s2    (s2)
    );

    tlp_hdr_decode u_decode (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_s1         (s1),
        .i_s2         (s2),
        .o_state_hdr  (state_hdr),
        .o_kind       (kind),
        .o_hdr_strobe (hdr_strobe),
        .o_mrd        (o_mrd),
        .o_mwr        (o_mwr),
        .o_cpld       (o_cpld)
    );

    tlp_payload_route u_route (
        .clk             (clk),
        .rst_n           (rst_n),
        .i_s2            (s2),
        .i_state_hdr     (state_hdr),
        .i_kind          (kind),
        .o_mwr_beat      (o_mwr_beat),
        .o_mwr_wr_start  (o_mwr_wr_start),
        .o_cpld_beat     (o_cpld_beat),
        .o_cpld_wr_start (o_cpld_wr_start),
        .o_bar_hit       (o_bar_hit)
    );

    // last-completion flag rides in the s2 user sideband
    tlp_rcv_flow_ctrl u_flow (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_hdr_strobe   (hdr_strobe),
        .i_kind         (kind),
        .i_last_cpl     (s2.user[USER_LAST_CPL_BIT]),
        .i_cpld_req_rdy (i_cpld_req_rdy),
        .i_cpld_tx_rdy  (i_cpld_tx_rdy),
        .i_tag_full     (i_tag_full),
        .o_cpld_req_vld (o_cpld_req_vld),
        .o_cpld_rcv     (o_cpld_rcv),
        .o_pkt_halt     (o_pkt_halt)
    );

endmodule

// ==== include/tlp_ref_model.svh ====
// reference model included in the body of the receive testbench
// header beats use little endian DW order with DW0 in bits 31:0
`ifndef TLP_REF_MODEL_SVH
`define TLP_REF_MODEL_SVH

// MRd/MWr header beat where fmt bit 29 picks the 64-bit address form
function automatic logic [127:0] req_hdr_beat(input logic [7:0] fmt_type,
    input logic [9:0] len, input logic [15:0] req_id, input logic [7:0] tag,
    input logic [7:0] dwbe, input logic [2:0] tc, input logic [2:0] attr,
    input logic [63:0] addr);
    logic [31:0] dw0;
    logic [31:0] dw1;
    dw0 = {fmt_type, 1'b0, tc, 1'b0, attr[2], 4'b0, attr[1:0], 2'b0, len};
    dw1 = {req_id, tag, dwbe};
    if (fmt_type[5])
        return {addr[31:2], 2'b00, addr[63:32], dw1, dw0};
    return {32'h0, addr[31:2], 2'b00, dw1, dw0};
endfunction

// completion header with the completer id fixed at zero
function automatic logic [127:0] cpl_hdr_beat(input logic [7:0] fmt_type,
    input logic [9:0] len, input logic [11:0] byte_cnt, input logic [15:0] req_id,
    input logic [7:0] tag, input logic [6:0] low_addr);
    logic [31:0] dw0;
    dw0 = {fmt_type, 14'b0, len};
    return {32'h0, req_id, tag, 1'b0, low_addr, 16'h0, 4'b0, byte_cnt, dw0};
endfunction

function automatic tlp_rcv_pkg::mrd_req_t mrd_fields(input logic [7:0] fmt_type,
    input logic [9:0] len, input logic [15:0] req_id, input logic [7:0] tag,
    input logic [2:0] tc, input logic [2:0] attr, input logic [63:0] addr);
    logic [63:0] exp_addr;
    exp_addr = fmt_type[5] ? {addr[63:2], 2'b00} : {32'h0, addr[31:2], 2'b00};
    return '{tc: tc, attr: attr, len: len, req_id: req_id, tag: tag, addr: exp_addr};
endfunction

function automatic tlp_rcv_pkg::mwr_hdr_t mwr_fields(input logic [7:0] fmt_type,
    input logic [9:0] len, input logic [7:0] dwbe, input logic [63:0] addr);
    logic [63:0] exp_addr;
    exp_addr = fmt_type[5] ? {addr[63:2], 2'b00} : {32'h0, addr[31:2], 2'b00};
    return '{len: len, dwbe: dwbe, addr: exp_addr};
endfunction

// multi-completion flag is set when this is not the last completion
function automatic tlp_rcv_pkg::cpld_hdr_t cpld_fields(input logic [9:0] len,
    input logic [6:0] low_addr, input logic [11:0] byte_cnt, input logic [7:0] tag,
    input logic last_cpl);
    return '{len: len, low_addr: low_addr, byte_cnt: byte_cnt, tag: tag,
             multi_cpl: ~last_cpl};
endfunction

// byte k of the beat lands on byte k^3 inside its DW
function automatic tlp_rcv_pkg::data_beat_t swapped_beat(input logic [127:0] data,
    input logic [3:0] keep);
    tlp_rcv_pkg::data_beat_t res;
    for (int k = 0; k < 16; k++)
        res.data[8*(k ^ 3) +: 8] = data[8*k +: 8];
    res.dw_vld = keep;
    return res;
endfunction

`endif

// ==== sim/tb_tlp_rcv.sv ====
// self-checking testbench for the TLP receive path
// expected items are queued per strobe and popped when the strobe is seen
// outputs are sampled at the rising edge
`timescale 1ns/1ps

module tb_tlp_rcv;

    import tlp_rcv_pkg::*;

    `include "tlp_ref_model.svh"

    logic        clk;
    logic        rst_n;
    axis_beat_t  i_axis;
    logic        o_axis_trdy;
    mrd_req_t    o_mrd;
    logic        o_cpld_req_vld;
    logic        i_cpld_req_rdy;
    logic        i_cpld_tx_rdy;
    mwr_hdr_t    o_mwr;
    data_beat_t  o_mwr_beat;
    logic        o_mwr_wr_start;
    cpld_hdr_t   o_cpld;
    data_beat_t  o_cpld_beat;
    logic        o_cpld_wr_start;
    logic        o_multicpld_flag;
    logic [1:0]  o_bar_hit;
    logic        o_cpld_rcv;
    logic        i_tag_full;
    logic [2:0]  o_pkt_halt;

    integer      seed = 87972;
    mrd_req_t    mrd_q[$];
    mwr_hdr_t    mwr_hdr_q[$];
    data_beat_t  mwr_beat_q[$];
    logic [1:0]  mwr_bar_q[$];
    cpld_hdr_t   cpld_hdr_q[$];
    data_beat_t  cpld_beat_q[$];
    logic [1:0]  cpld_bar_q[$];
    int          rcv_exp;
    int          rcv_seen;
    logic        vld_q;
    logic        rcv_q;
    logic        halt_armed;
    logic [2:0]  halt_exp;

    tlp_rcv_top i_dut (.*);

    initial
    begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // reference and compare helpers
    //////////////////////////////////////////////////////////////////////
    function automatic logic [127:0] rand_data();
        return {$random(seed), $random(seed), $random(seed), $random(seed)};
    endfunction

    task automatic report_failure(input string line);
        $display("TEST FAIL");
        $display("%s", line);
        $fatal(1, "simulation stopped at first failure");
    endtask

    task automatic check_mrd(input mrd_req_t act, input mrd_req_t exp_v);
        if (act !== exp_v)
            report_failure($sformatf("Error: o_mrd got %h expected %h", act, exp_v));
    endtask

    task automatic check_mwr_hdr(input mwr_hdr_t act, input mwr_hdr_t exp_v);
        if (act !== exp_v)
            report_failure($sformatf("Error: o_mwr got %h expected %h", act, exp_v));
    endtask

    task automatic check_cpld_hdr(input cpld_hdr_t act, input cpld_hdr_t exp_v);
        if (act !== exp_v)
            report_failure($sformatf("Error: o_cpld got %h expected %h", act, exp_v));
    endtask

    task automatic check_beat(input string name, input data_beat_t act,
        input data_beat_t exp_v);
        if (act !== exp_v)
            report_failure($sformatf("Error: %s got %h expected %h", name, act, exp_v));
    endtask

    task automatic check_halt(input logic [2:0] act, input logic [2:0] exp_v);
        if (act !== exp_v)
            report_failure($sformatf("Error: o_pkt_halt got %h expected %h", act, exp_v));
    endtask

    // flags, bar hit and pulse counts
    task automatic check_bits(input string name, input logic [11:0] act,
        input logic [11:0] exp_v);
        if (act !== exp_v)
            report_failure($sformatf("Error: %s got %h expected %h", name, act, exp_v));
    endtask

    //////////////////////////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////////////////////////
    task automatic drive_beat(input logic [127:0] data, input logic [3:0] keep,
        input logic last, input logic [7:0] user);
        @(posedge clk);
        #0.5;
        i_axis = '{valid: 1'b1, data: data, keep: keep, last: last, user: user};
    endtask

    task automatic drive_idle(input int cycles);
        repeat (cycles)
        begin
            @(posedge clk);
            #0.5;
            i_axis = '0;
        end
    endtask

    task automatic send_mrd(input logic [7:0] fmt);
        logic [63:0] addr;
        logic [9:0]  len;
        logic [7:0]  tag;
        logic [2:0]  tc;
        logic [2:0]  attr;
        addr = {$random(seed), $random(seed)};
        len  = $random(seed);
        tag  = $random(seed);
        tc   = $random(seed);
        attr = $random(seed);
        mrd_q.push_back(mrd_fields(fmt, len, 16'h0100, tag, tc, attr, addr));
        drive_beat(req_hdr_beat(fmt, len, 16'h0100, tag, 8'h0f, tc, attr, addr),
                   4'hf, 1'b1, 8'h00);
    endtask

    // payload beats full except the last one
    task automatic send_mwr(input logic [7:0] fmt, input int beats);
        logic [63:0]  addr;
        logic [127:0] data;
        logic [3:0]   keep;
        logic [1:0]   bar;
        logic [9:0]   len;
        mwr_hdr_t     hdr;
        addr = {$random(seed), $random(seed)};
        bar  = $random(seed);
        len  = 4 * beats;
        hdr  = mwr_fields(fmt, len, 8'hff, addr);
        drive_beat(req_hdr_beat(fmt, len, 16'h0100, 8'h00, 8'hff, 3'b0, 3'b0, addr),
                   4'hf, 1'b0, {2'b00, bar, 4'h0});
        for (int n = 0; n < beats; n++)
        begin
            data = rand_data();
            keep = (n == beats - 1) ? (4'hf >> ($random(seed) & 3)) : 4'hf;
            mwr_hdr_q.push_back(hdr);
            mwr_beat_q.push_back(swapped_beat(data, keep));
            mwr_bar_q.push_back(bar);
            drive_beat(data, keep, n == beats - 1, {2'b00, bar, 4'h0});
        end
    endtask

    task automatic send_cpld(input logic last_cpl, input int beats, input logic locked);
        logic [127:0] data;
        logic [1:0]   bar;
        logic [9:0]   len;
        logic [6:0]   low_addr;
        logic [11:0]  byte_cnt;
        logic [7:0]   tag;
        logic [7:0]   user;
        cpld_hdr_t    hdr;
        bar      = $random(seed);
        len      = 4 * beats;
        low_addr = $random(seed);
        byte_cnt = $random(seed);
        tag      = $random(seed);
        user     = {2'b00, bar, last_cpl, 3'b000};
        hdr      = cpld_fields(len, low_addr, byte_cnt, tag, last_cpl);
        if (last_cpl)
            rcv_exp++;
        drive_beat(cpl_hdr_beat(locked ? TLP_CPLDLK : TLP_CPLD, len, byte_cnt, 16'h0100,
                                tag, low_addr), 4'h7, 1'b0, user);
        for (int n = 0; n < beats; n++)
        begin
            data = rand_data();
            cpld_hdr_q.push_back(hdr);
            cpld_beat_q.push_back(swapped_beat(data, 4'hf));
            cpld_bar_q.push_back(bar);
            drive_beat(data, 4'hf, n == beats - 1, user);
        end
    endtask

    // message with data that the DUT does not decode
    task automatic send_msg();
        drive_beat(req_hdr_beat(8'h72, 10'd4, 16'h0100, 8'h00, 8'h00, 3'b0, 3'b0, 64'h0),
                   4'hf, 1'b0, 8'h30);
        drive_beat(rand_data(), 4'hf, 1'b1, 8'h30);
    endtask

    task automatic wait_req(input logic level, input int limit, input string what);
        int cnt;
        cnt = 0;
        while (o_cpld_req_vld !== level)
        begin
            @(posedge clk);
            cnt++;
            if (cnt > limit)
                report_failure($sformatf("timed out waiting for the %s", what));
        end
    endtask

    task automatic run_read(input logic [7:0] fmt);
        int hold;
        send_mrd(fmt);
        drive_idle(1);
        wait_req(1'b1, 20, "completion request");
        hold = 1 + ($random(seed) & 7);
        repeat (hold)
        begin
            @(posedge clk);
            check_bits("o_cpld_req_vld", o_cpld_req_vld, 1);
        end
        #0.5;
        i_cpld_req_rdy = 1'b1;
        @(posedge clk);
        #0.5;
        i_cpld_req_rdy = 1'b0;
        wait_req(1'b0, 4, "completion request release");
    endtask

    task automatic wait_drain(input int limit);
        int cnt;
        cnt = 0;
        while (mrd_q.size() + mwr_beat_q.size() + cpld_beat_q.size() != 0)
        begin
            @(posedge clk);
            cnt++;
            if (cnt > limit)
                report_failure("expected items still pending after the stream ended");
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // checking process
    //////////////////////////////////////////////////////////////////////
    always @(posedge clk)
    begin
        if (!rst_n)
        begin
            vld_q      <= 1'b0;
            rcv_q      <= 1'b0;
            halt_armed <= 1'b0;
        end
        else
        begin
            // input side never stalls
            check_bits("o_axis_trdy", o_axis_trdy, 1);
            if (o_cpld_req_vld && !vld_q)
            begin
                if (mrd_q.size() == 0)
                    report_failure("completion request raised with no read pending");
                else
                    check_mrd(o_mrd, mrd_q.pop_front());
            end
            if (o_mwr_wr_start)
            begin
                if (mwr_beat_q.size() == 0)
                    report_failure("write strobe seen with no write beat expected");
                else
                begin
                    check_mwr_hdr(o_mwr, mwr_hdr_q.pop_front());
                    check_beat("o_mwr_beat", o_mwr_beat, mwr_beat_q.pop_front());
                    check_bits("o_bar_hit", o_bar_hit, mwr_bar_q.pop_front());
                end
            end
            if (o_cpld_wr_start)
            begin
                if (cpld_beat_q.size() == 0)
                    report_failure("completion strobe seen with no completion beat expected");
                else
                begin
                    check_bits("o_multicpld_flag", o_multicpld_flag,
                               cpld_hdr_q[0].multi_cpl);
                    check_cpld_hdr(o_cpld, cpld_hdr_q.pop_front());
                    check_beat("o_cpld_beat", o_cpld_beat, cpld_beat_q.pop_front());
                    check_bits("o_bar_hit", o_bar_hit, cpld_bar_q.pop_front());
                end
            end
            // release comes with the header of a last completion
            if (o_cpld_rcv)
            begin
                if (rcv_q)
                    report_failure("tag release pulse lasted more than one cycle");
                check_bits("o_multicpld_flag", o_multicpld_flag, 0);
                rcv_seen++;
            end
            if (halt_armed)
                check_halt(o_pkt_halt, halt_exp);
            vld_q      <= o_cpld_req_vld;
            rcv_q      <= o_cpld_rcv;
            halt_armed <= 1'b1;
        end
        halt_exp <= {i_tag_full, ~i_cpld_tx_rdy, 1'b0};
    end

    initial
    begin
        rst_n          = 1'b0;
        i_axis         = '0;
        i_cpld_req_rdy = 1'b0;
        i_cpld_tx_rdy  = 1'b1;
        i_tag_full     = 1'b0;
        rcv_exp        = 0;
        rcv_seen       = 0;
        repeat (8) @(posedge clk);
        #0.5;
        rst_n = 1'b1;
        @(posedge clk);
        check_bits("o_cpld_req_vld", o_cpld_req_vld, 0);
        check_bits("o_mwr_wr_start", o_mwr_wr_start, 0);
        check_bits("o_cpld_wr_start", o_cpld_wr_start, 0);
        check_bits("o_cpld_rcv", o_cpld_rcv, 0);
        check_halt(o_pkt_halt, 3'b000);
        drive_idle(2);

        // reads with the request held off
        run_read(TLP_MRD32);
        run_read(TLP_MRD64);
        run_read(TLP_MRDLK32);
        run_read(TLP_MRDLK64);

        for (int n = 1; n <= 4; n++)
        begin
            send_mwr(TLP_MWR32, n);
            send_mwr(TLP_MWR64, n);
        end
        drive_idle(2);

        send_cpld(1'b1, 2, 1'b0);
        send_cpld(1'b0, 1, 1'b0);
        send_cpld(1'b1, 3, 1'b1);
        drive_idle(2);

        // back to back mix with a single read so the request edge stays visible
        i_cpld_req_rdy = 1'b1;
        send_mwr(TLP_MWR64, 2);
        send_mrd(TLP_MRD32);
        send_cpld(1'b0, 1, 1'b0);
        send_msg();
        send_mwr(TLP_MWR32, 1);
        send_cpld(1'b1, 2, 1'b0);
        drive_idle(1);
        wait_drain(40);
        #0.5;
        i_cpld_req_rdy = 1'b0;

        // halt vector follows random levels
        repeat (40)
        begin
            @(posedge clk);
            #0.5;
            i_cpld_tx_rdy = $random(seed);
            i_tag_full    = $random(seed);
        end
        i_cpld_tx_rdy = 1'b1;
        i_tag_full    = 1'b0;
        drive_idle(4);

        wait_drain(10);
        if (rcv_seen != rcv_exp)
            report_failure($sformatf("Error: o_cpld_rcv pulse count got %h expected %h",
                                     rcv_seen, rcv_exp));
        else
        begin
            $display("TEST PASS");
            $finish;
        end
    end

endmodule

// ==== all.f ====
+incdir+include
source/tlp_rcv_pkg.sv
source/axis_rx_pipe.sv
source/tlp_hdr_decode.sv
source/tlp_payload_route.sv
source/tlp_rcv_flow_ctrl.sv
source/tlp_rcv_top.sv
sim/tb_tlp_rcv.sv

// ==== Bender.yml ====
package:
  name: tlp_rcv

sources:
  - files:
      - source/tlp_rcv_pkg.sv
      - source/axis_rx_pipe.sv
      - source/tlp_hdr_decode.sv
      - source/tlp_payload_route.sv
      - source/tlp_rcv_flow_ctrl.sv
      - source/tlp_rcv_top.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tb_tlp_rcv.sv
